// File: exec_consts.svh
// Execute stage constants
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

`define XLEN      32           // Data path width
`define UOP_W     12           // Micro-op width

// Micro-op field ranges
`define UNIT      1:0          // Functional unit select
`define ALU_OP    5:2          // ALU op, low two bits pick the multiply variant
`define BR_COND   8:6          // Branch condition
`define WB_CTRL   `UOP_W-1:9   // Write enable, select PC next, spare

// Functional units
`define UNIT_NONE 2'd0
`define UNIT_ALU  2'd1
`define UNIT_MUL  2'd2

// ALU operations
`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_SLL   4'd2
`define ALU_SLT   4'd3
`define ALU_SLTU  4'd4
`define ALU_XOR   4'd5
`define ALU_SRL   4'd6
`define ALU_SRA   4'd7
`define ALU_OR    4'd8
`define ALU_AND   4'd9

// Multiplier variants
`define MUL_LO    2'd0         // Low word, sign does not matter
`define MUL_HSS   2'd1         // High word, signed x signed
`define MUL_HUU   2'd2         // High word, unsigned x unsigned
`define MUL_HSU   2'd3         // High word, signed x unsigned

// Branch conditions
`define BR_NONE   3'd0
`define BR_EQ     3'd1
`define BR_NE     3'd2
`define BR_LT     3'd3
`define BR_GE     3'd4
`define BR_LTU    3'd5
`define BR_GEU    3'd6

// Instruction kinds
`define KIND_OTHER 2'd0
`define KIND_J     2'd1
`define KIND_B     2'd2

`define MUL_STEPS 32           // One step per multiplier bit

`endif

// File: exec_pkg.sv
// Execute stage types
`default_nettype none

package exec_pkg;

    // Data and addressing
    typedef logic [31:0] word_t;      // Register sized data word
    typedef logic [4:0]  reg_addr_t;  // Register file index

    // Micro-op and its fields
    typedef logic [11:0] uop_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  br_cond_t;
    typedef logic [2:0]  wb_ctrl_t;   // Passed to writeback untouched

    // J, B or anything else
    typedef logic [1:0]  kind_t;

    // Compare results from decode, {lt, ltu, eq}
    typedef logic [2:0]  cmp_flags_t;

    // Iterative multiplier FSM
    typedef enum logic [0:0] {
        IDLE,
        RUN
    } mul_state_t;

endpackage

`default_nettype wire

// File: alu.sv
// Arithmetic logic unit
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module alu (
    input  exec_pkg::word_t   operand_a_i,
    input  exec_pkg::word_t   operand_b_i,
    input  exec_pkg::alu_op_t op_i,
    input  logic              lt_i,      // Signed less-than from decode
    input  logic              ltu_i,     // Unsigned less-than from decode
    output exec_pkg::word_t   result_o
);

    import exec_pkg::*;

    word_t      sum_w;      // Also the branch and jump target
    word_t      diff_w;
    logic [4:0] shamt_w;

    assign sum_w   = operand_a_i + operand_b_i;
    assign diff_w  = operand_a_i - operand_b_i;
    assign shamt_w = operand_b_i[4:0];  // RV32 shift amount

    always_comb begin
        case (op_i)
            `ALU_ADD: begin
                result_o = sum_w;
            end
            `ALU_SUB: begin
                result_o = diff_w;
            end
            `ALU_SLL: begin
                result_o = operand_a_i << shamt_w;
            end
            `ALU_SLT: begin
                result_o = {{(`XLEN-1){1'b0}}, lt_i};   // Compare reused from decode
            end
            `ALU_SLTU: begin
                result_o = {{(`XLEN-1){1'b0}}, ltu_i};
            end
            `ALU_XOR: begin
                result_o = operand_a_i ^ operand_b_i;
            end
            `ALU_SRL: begin
                result_o = operand_a_i >> shamt_w;
            end
            `ALU_SRA: begin
                // Sign bit fills from the left
                result_o = word_t'($signed(operand_a_i) >>> shamt_w);
            end
            `ALU_OR: begin
                result_o = operand_a_i | operand_b_i;
            end
            `ALU_AND: begin
                result_o = operand_a_i & operand_b_i;
            end
            default: begin
                result_o = '0;  // Unused codes
            end
        endcase
    end

endmodule

`default_nettype wire

// File: branch_unit.sv
// Branch decision unit
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module branch_unit (
    input  exec_pkg::br_cond_t   cond_i,
    input  exec_pkg::cmp_flags_t cmp_i,    // {lt, ltu, eq}
    input  exec_pkg::kind_t      kind_i,
    output logic                 taken_o
);

    import exec_pkg::*;

    logic cond_met_w;

    // Condition from the decode flags
    always_comb begin
        case (cond_i)
            `BR_EQ:  cond_met_w =  cmp_i[0];
            `BR_NE:  cond_met_w = !cmp_i[0];
            `BR_LT:  cond_met_w =  cmp_i[2];
            `BR_GE:  cond_met_w = !cmp_i[2];
            `BR_LTU: cond_met_w =  cmp_i[1];
            `BR_GEU: cond_met_w = !cmp_i[1];
            default: cond_met_w = 1'b0;   // BR_NONE and unknown codes never branch
        endcase
    end

    // Jumps always redirect and branches only on a met condition
    always_comb begin
        case (kind_i)
            `KIND_J: taken_o = 1'b1;
            `KIND_B: taken_o = cond_met_w;
            default: taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: mul_unit.sv
// Iterative shift-add multiplier
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module mul_unit (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            start_i,
    input  exec_pkg::word_t a_i,
    input  exec_pkg::word_t b_i,
    input  logic [1:0]      variant_i,
    output logic            busy_o,
    output logic            done_o,      // One cycle after the last step
    output exec_pkg::word_t product_o    // Held until the next start
);

    import exec_pkg::*;

    mul_state_t          state_q;
    logic [5:0]          step_q;                 // Steps taken so far
    logic [2*`XLEN-1:0]  acc_q;                  // Partial product of magnitudes
    logic [2*`XLEN-1:0]  mcand_q;                // Multiplicand, moves left each step
    word_t               mplier_q;               // Multiplier, moves right each step
    logic                neg_q;                  // Result sign
    logic                hi_q;                   // Return the upper word
    logic                a_neg_w;
    logic                b_neg_w;
    word_t               a_mag_w;
    word_t               b_mag_w;
    logic                last_w;
    logic [2*`XLEN-1:0]  acc_next_w;
    logic [2*`XLEN-1:0]  final_w;

    // Operand signs by variant
    assign a_neg_w = a_i[31] && (variant_i == `MUL_HSS || variant_i == `MUL_HSU);
    assign b_neg_w = b_i[31] && (variant_i == `MUL_HSS);
    assign a_mag_w = a_neg_w ? ~a_i + 1'b1 : a_i;
    assign b_mag_w = b_neg_w ? ~b_i + 1'b1 : b_i;

    assign last_w     = (step_q == 6'(`MUL_STEPS - 1));
    assign acc_next_w = acc_q + (mplier_q[0] ? mcand_q : '0);
    assign final_w    = neg_q ? ~acc_next_w + 1'b1 : acc_next_w;   // Sign correction

    assign busy_o = (state_q == RUN);

    // Control FSM
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            step_q  <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= RUN;
                        step_q  <= '0;
                    end
                end
                RUN: begin
                    step_q <= step_q + 1'b1;
                    if (last_w) begin
                        state_q <= IDLE;
                        done_o  <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Shift-add datapath
    always_ff @(posedge clk_i) begin
        if (start_i && state_q == IDLE) begin
            acc_q    <= '0;
            mcand_q  <= {{`XLEN{1'b0}}, a_mag_w};
            mplier_q <= b_mag_w;
            neg_q    <= a_neg_w ^ b_neg_w;
            hi_q     <= (variant_i != `MUL_LO);
        end else if (state_q == RUN) begin
            acc_q    <= acc_next_w;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
            if (last_w) begin
                product_o <= hi_q ? final_w[2*`XLEN-1:`XLEN] : final_w[`XLEN-1:0];
            end
        end
    end

    // Issue only into an idle unit
    assert property (@(posedge clk_i) disable iff (rst_i) start_i |-> !busy_o)
        else $error("multiply started while busy");

    // Done is a single pulse
    assert property (@(posedge clk_i) disable iff (rst_i) done_o |=> !done_o)
        else $error("done held for more than one cycle");

endmodule

`default_nettype wire

// File: execute_stage.sv
// Pipeline execute stage
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module execute_stage (
    input  logic                 clk_i,
    input  logic                 rst_i,

    // From decode, held while ready_o is low
    input  exec_pkg::uop_t       uop_i,
    input  exec_pkg::reg_addr_t  rd_addr_i,
    input  exec_pkg::word_t      pc_next_i,         // PC plus 4 or 2 for link writes
    input  exec_pkg::word_t      operand_a_i,       // Forwarded with the immediate already picked
    input  exec_pkg::word_t      operand_b_i,
    input  exec_pkg::cmp_flags_t cmp_flags_i,       // {lt, ltu, eq}
    input  exec_pkg::kind_t      kind_i,

    // Pipeline control
    output logic                 ready_o,

    // Fetch redirect
    output logic                 branch_taken_o,
    output logic [31:1]          branch_target_o,

    // To writeback
    output exec_pkg::reg_addr_t  wb_rd_addr_o,
    output exec_pkg::word_t      wb_pc_next_o,
    output exec_pkg::word_t      wb_rd_value_o,
    output exec_pkg::wb_ctrl_t   wb_ctrl_o,         // Zero means bubble

    // To decode forwarding
    output exec_pkg::word_t      fwd_value_o
);

    import exec_pkg::*;

    // Micro-op fields
    logic [1:0] unit_w;
    alu_op_t    alu_op_w;
    br_cond_t   br_cond_w;
    wb_ctrl_t   wb_ctrl_w;

    word_t      alu_result_w;
    word_t      mul_product_w;
    word_t      next_result_w;
    logic       is_mul_w;
    logic       mul_start_w;
    logic       mul_busy_w;
    logic       mul_done_w;

    assign unit_w    = uop_i[`UNIT];
    assign alu_op_w  = uop_i[`ALU_OP];
    assign br_cond_w = uop_i[`BR_COND];
    assign wb_ctrl_w = uop_i[`WB_CTRL];

    alu u_alu (
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .op_i        (alu_op_w),
        .lt_i        (cmp_flags_i[2]),
        .ltu_i       (cmp_flags_i[1]),
        .result_o    (alu_result_w)
    );

    branch_unit u_branch_unit (
        .cond_i  (br_cond_w),
        .cmp_i   (cmp_flags_i),
        .kind_i  (kind_i),
        .taken_o (branch_taken_o)
    );

    mul_unit u_mul_unit (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .start_i   (mul_start_w),
        .a_i       (operand_a_i),
        .b_i       (operand_b_i),
        .variant_i (alu_op_w[1:0]),   // Variant rides in the low ALU op bits
        .busy_o    (mul_busy_w),
        .done_o    (mul_done_w),
        .product_o (mul_product_w)
    );

    assign is_mul_w = (unit_w == `UNIT_MUL);

    // Issue once and not again in the done cycle while the op is held
    assign mul_start_w = is_mul_w && !mul_busy_w && !mul_done_w;

    // Stall from issue until the product is ready
    assign ready_o = !is_mul_w || mul_done_w;

    // Next result by unit
    always_comb begin
        case (unit_w)
            `UNIT_ALU: next_result_w = alu_result_w;
            `UNIT_MUL: next_result_w = mul_done_w ? mul_product_w : '0;
            default:   next_result_w = '0;
        endcase
    end

    assign fwd_value_o     = next_result_w;
    assign branch_target_o = alu_result_w[31:1];   // Sum of base and offset

    // Writeback registers load a bubble while stalled
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_ctrl_o     <= '0;
            wb_rd_addr_o  <= '0;
            wb_rd_value_o <= '0;
        end else begin
            wb_ctrl_o     <= ready_o ? wb_ctrl_w : '0;
            wb_rd_addr_o  <= rd_addr_i;
            wb_rd_value_o <= next_result_w;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_pc_next_o <= pc_next_i;
    end

    // Upstream holds the op steady through a stall
    assert property (@(posedge clk_i) disable iff (rst_i)
        !ready_o |=> $stable(uop_i) && $stable(rd_addr_i) && $stable(pc_next_i)
                     && $stable(operand_a_i) && $stable(operand_b_i))
        else $error("held inputs changed while the stage was stalled");

endmodule

`default_nettype wire

// File: tb_execute_stage.sv
// Execute stage testbench
`timescale 1ns/1ns
`default_nettype none

`include "exec_consts.svh"

module tb_execute_stage;

    import exec_pkg::*;

    // About 1100 cycles of tests, the limit leaves a wide margin
    localparam int CYCLE_LIMIT = 4000;

    logic        clk = 1'b0;
    logic        rst;
    uop_t        uop;
    reg_addr_t   rd_addr;
    word_t       pc_next;
    word_t       op_a;
    word_t       op_b;
    cmp_flags_t  flags;                 // {lt, ltu, eq}
    kind_t       kind;
    logic        ready;
    logic        br_taken;
    logic [31:1] br_target;
    reg_addr_t   wb_rd_addr;
    word_t       wb_pc_next;
    word_t       wb_rd_value;
    wb_ctrl_t    wb_ctrl;
    word_t       fwd_value;

    word_t       lcg_state = 32'd84;   // Seed
    int unsigned cycles = 0;
    int          errors = 0;
    int          checks = 0;

    // Writeback set expected after the next edge
    reg_addr_t   exp_rd;
    word_t       exp_pc;
    word_t       exp_val;
    wb_ctrl_t    exp_ctrl;

    execute_stage u_execute_stage (
        .clk_i           (clk),
        .rst_i           (rst),
        .uop_i           (uop),
        .rd_addr_i       (rd_addr),
        .pc_next_i       (pc_next),
        .operand_a_i     (op_a),
        .operand_b_i     (op_b),
        .cmp_flags_i     (flags),
        .kind_i          (kind),
        .ready_o         (ready),
        .branch_taken_o  (br_taken),
        .branch_target_o (br_target),
        .wb_rd_addr_o    (wb_rd_addr),
        .wb_pc_next_o    (wb_pc_next),
        .wb_rd_value_o   (wb_rd_value),
        .wb_ctrl_o       (wb_ctrl),
        .fwd_value_o     (fwd_value)
    );

    always #2 clk = ~clk;  // 4 ns period

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout: tests still running after %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_equal(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes constants
        return lcg_state;
    endfunction

    function automatic uop_t make_uop(logic [1:0] unit, alu_op_t op, br_cond_t cond,
                                      wb_ctrl_t ctrl);
        return {ctrl, cond, op, unit};
    endfunction

    // Compare flags as decode would supply them
    function automatic cmp_flags_t flags_of(word_t a, word_t b);
        return {$signed(a) < $signed(b), a < b, a == b};
    endfunction

    function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
        logic [63:0] ext;
        ext = {{32{a[31]}}, a} >> b[4:0];  // Arithmetic shift via sign-extended word
        case (op)
            `ALU_ADD:  return a + b;
            `ALU_SUB:  return a - b;
            `ALU_SLL:  return a << b[4:0];
            `ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
            `ALU_SLTU: return {31'd0, a < b};
            `ALU_XOR:  return a ^ b;
            `ALU_SRL:  return a >> b[4:0];
            `ALU_SRA:  return ext[31:0];
            `ALU_OR:   return a | b;
            `ALU_AND:  return a & b;
            default:   return 32'd0;
        endcase
    endfunction

    function automatic logic branch_model(br_cond_t cond, cmp_flags_t f, kind_t k);
        logic hit;
        case (cond)
            `BR_EQ:  hit = f[0];
            `BR_NE:  hit = !f[0];
            `BR_LT:  hit = f[2];
            `BR_GE:  hit = !f[2];
            `BR_LTU: hit = f[1];
            `BR_GEU: hit = !f[1];
            default: hit = 1'b0;  // None and unused codes
        endcase
        if (k == `KIND_J) begin
            return 1'b1;
        end
        return (k == `KIND_B) && hit;
    endfunction

    // Full 64-bit product, operands extended by the variant's signedness
    function automatic word_t mul_model(logic [1:0] variant, word_t a, word_t b);
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] p;
        sa = {(variant == `MUL_HSS || variant == `MUL_HSU) ? {32{a[31]}} : 32'd0, a};
        sb = {(variant == `MUL_HSS) ? {32{b[31]}} : 32'd0, b};
        p  = sa * sb;
        return (variant == `MUL_LO) ? p[31:0] : p[63:32];
    endfunction

    // Apply one op with fresh rd and pc_next
    task automatic drive_op(input uop_t u, input word_t a, input word_t b,
                            input cmp_flags_t f, input kind_t k);
        uop      = u;
        op_a     = a;
        op_b     = b;
        flags    = f;
        kind     = k;
        rd_addr  = reg_addr_t'(next_rand());
        pc_next  = next_rand();
        exp_rd   = rd_addr;
        exp_pc   = pc_next;
        exp_ctrl = u[`WB_CTRL];
    endtask

    task automatic check_wb(input string tag);
        check_equal(word_t'(wb_rd_addr), word_t'(exp_rd), {tag, " rd address"});
        check_equal(wb_pc_next, exp_pc, {tag, " pc next"});
        check_equal(wb_rd_value, exp_val, {tag, " rd value"});
        check_equal(word_t'(wb_ctrl), word_t'(exp_ctrl), {tag, " wb control"});
    endtask

    task automatic present_random_alu();
        word_t   a;
        word_t   b;
        alu_op_t op;
        a  = next_rand();
        b  = next_rand();
        op = alu_op_t'(next_rand() % 10);  // All ten codes
        drive_op(make_uop(`UNIT_ALU, op, `BR_NONE, wb_ctrl_t'(next_rand())), a, b,
                 flags_of(a, b), `KIND_OTHER);
        exp_val = alu_model(op, a, b);
        #1;
        check_equal(fwd_value, exp_val, "ALU forward value");
    endtask

    task automatic present_none();
        drive_op(make_uop(`UNIT_NONE, `ALU_ADD, `BR_NONE, 3'b000), next_rand(), next_rand(),
                 3'b000, `KIND_OTHER);
        exp_val = 32'd0;
        #1;
        check_equal(fwd_value, 32'd0, "idle forward value");
    endtask

    task automatic test_reset();
        #1;
        check_equal(word_t'(wb_ctrl), 32'd0, "wb control after reset");
        check_equal(word_t'(wb_rd_addr), 32'd0, "rd address after reset");
        check_equal(wb_rd_value, 32'd0, "rd value after reset");
        check_equal(word_t'(ready), 32'd1, "ready after reset");
        check_equal(word_t'(br_taken), 32'd0, "branch taken after reset");
        $display("reset test done, %0d errors so far", errors);
    endtask

    // Each ALU op followed by an idle slot
    task automatic test_random_alu();
        @(negedge clk);
        repeat (60) begin
            present_random_alu();
            @(negedge clk);
            check_wb("random ALU");
            present_none();
            @(negedge clk);
            check_wb("idle slot");
        end
        $display("random ALU test done, %0d errors so far", errors);
    endtask

    task automatic test_back_to_back();
        @(negedge clk);
        present_random_alu();
        repeat (99) begin
            @(negedge clk);
            check_wb("back-to-back ALU");  // Op from one edge earlier
            present_random_alu();
        end
        @(negedge clk);
        check_wb("back-to-back ALU");
        $display("back-to-back ALU test done, %0d errors so far", errors);
    endtask

    task automatic test_branches();
        word_t a;
        word_t b;
        word_t sum;
        int    k;
        int    c;
        int    f;
        for (k = 0; k < 3; k++) begin  // Other, jump, branch
            for (c = 0; c < 8; c++) begin
                for (f = 0; f < 8; f++) begin
                    @(negedge clk);
                    a   = next_rand();
                    b   = next_rand();
                    sum = a + b;
                    drive_op(make_uop(`UNIT_ALU, `ALU_ADD, br_cond_t'(c), 3'b000), a, b,
                             cmp_flags_t'(f), kind_t'(k));
                    #1;
                    check_equal(word_t'(br_taken),
                                word_t'(branch_model(br_cond_t'(c), cmp_flags_t'(f), kind_t'(k))),
                                "branch taken");
                    check_equal(word_t'(br_target), word_t'(sum[31:1]), "branch target");
                end
            end
        end
        $display("branch test done, %0d errors so far", errors);
    endtask

    task automatic test_multiplies();
        word_t a;
        word_t b;
        word_t expected;
        int    v;
        int    p;
        int    waited;
        @(negedge clk);
        for (v = 0; v < 4; v++) begin
            for (p = 0; p < 4; p++) begin
                case (p)
                    0: begin
                        a = next_rand();
                        b = next_rand();
                    end
                    1: begin
                        a = 32'hFFFF_FFF9;  // Minus 7 times 13
                        b = 32'd13;
                    end
                    2: begin
                        a = 32'h8000_0000;  // Most negative squared
                        b = 32'h8000_0000;
                    end
                    default: begin
                        a = 32'h7FFF_FFFF;
                        b = 32'hFFFF_FFFF;
                    end
                endcase
                expected = mul_model(v[1:0], a, b);
                drive_op(make_uop(`UNIT_MUL, alu_op_t'(v), `BR_NONE,
                                  wb_ctrl_t'(next_rand()) | 3'b001), a, b, flags_of(a, b),
                         `KIND_OTHER);
                exp_val = expected;
                #1;
                check_equal(word_t'(ready), 32'd0, "ready at multiply issue");
                waited = 0;
                do begin
                    @(negedge clk);
                    check_equal(word_t'(wb_ctrl), 32'd0, "bubble during multiply");
                    waited++;
                end while (!ready && waited < `MUL_STEPS + 4);
                if (!ready) begin
                    errors++;
                    $display("Multiply did not complete, ready_o still low after %0d cycles",
                             waited);
                end else begin
                    check_equal(fwd_value, expected, "product on forward path");
                    @(negedge clk);
                    check_wb("multiply");  // Next op goes on at this same edge
                end
            end
        end
        present_none();  // Stop the held multiply from issuing again
        $display("multiply test done, %0d errors so far", errors);
    endtask

    initial begin
        rst     = 1'b1;
        uop     = '0;
        rd_addr = '0;
        pc_next = '0;
        op_a    = '0;
        op_b    = '0;
        flags   = '0;
        kind    = `KIND_OTHER;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_random_alu();
        test_back_to_back();
        test_branches();
        test_multiplies();
        $display("%0d checks run, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
exec_pkg.sv
alu.sv
branch_unit.sv
mul_unit.sv
execute_stage.sv
tb_execute_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --timing -f compile.f --top-module tb_execute_stage \
    -o tb_execute_stage \
    && ./obj_dir/tb_execute_stage > sim.log 2>&1 \
    || echo "Checks failed: build or simulation error" >> sim.log

grep -q "Checks failed" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
